//--- all.f
+incdir+include
verilog/ex_core_pkg.sv
verilog/ex_isa_pkg.sv
verilog/ex_ctrl_if.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_lsu.sv
verilog/ex_writeback.sv
verilog/ex_top.sv
bench/tb_ex.sv

//--- run_sim.sh
#!/bin/sh
# build tb_ex with Verilator, run it and judge the result from the log

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_ex -o tb_ex_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- include/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

typedef struct {
    logic  mem_req;
    logic  mem_we;
    xlen_t mem_raddr;
    xlen_t mem_waddr;
    xlen_t mem_wdata;
    logic  reg_we;
    xlen_t reg_wdata;
    logic  jump_flag;
    xlen_t jump_addr;
} ex_exp_t;

// word stored at the word address, salt varies the contents per test
function automatic xlen_t ex_mem_word(input xlen_t addr, input xlen_t salt);
    xlen_t waddr;
    waddr = {addr[31:2], 2'b00};
    return (waddr * 32'h9e37_79b9) ^ {waddr[15:0], ~waddr[31:16]} ^ salt;
endfunction

function automatic ex_exp_t ex_ref(input inst_u inst, input xlen_t op1, input xlen_t op2,
                                   input xlen_t op1_jump, input xlen_t op2_jump,
                                   input xlen_t reg1, input xlen_t reg2,
                                   input logic reg_we, input xlen_t rdata);
    ex_exp_t    e;
    op_class_e  cls;
    logic [2:0] f3;
    logic       alt;
    logic [4:0] amt;
    logic       taken;
    xlen_t      addr;
    xlen_t      alu;
    xlen_t      ld;
    xlen_t      mask;
    xlen_t      sdata;
    logic [7:0] b;
    logic [15:0] h;
    f3   = inst.r.funct3;
    addr = op1 + op2;
    cls  = op_none;
    case (inst.r.opcode)
        OPC_ALU_IMM: cls = op_alu_imm;
        OPC_ALU_REG: cls = op_alu_reg;
        OPC_BRANCH:  if (f3 != 3'b010 && f3 != 3'b011) cls = op_branch;
        OPC_LOAD:    if (f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) cls = op_load;
        OPC_STORE:   if (f3 inside {F3_SB, F3_SH, F3_SW}) cls = op_store;
        default:     cls = op_none;
    endcase
    alt = inst.r.funct7[5] && (cls == op_alu_reg || (cls == op_alu_imm && f3 == F3_SR));
    amt = (cls == op_alu_reg) ? reg2[4:0] : (cls == op_alu_imm) ? inst.i.imm[4:0] : 5'd0;
    case (f3)
        F3_ADD_SUB: alu = alt ? op1 - op2 : op1 + op2;
        F3_SLL:     alu = reg1 << amt;
        F3_SLT:     alu = xlen_t'($signed(op1) < $signed(op2));
        F3_SLTU:    alu = xlen_t'(op1 < op2);
        F3_XOR:     alu = op1 ^ op2;
        F3_SR:      alu = alt ? xlen_t'($signed(reg1) >>> amt) : reg1 >> amt;
        F3_OR:      alu = op1 | op2;
        default:    alu = op1 & op2;
    endcase
    case (f3)
        F3_BEQ:  taken = (op1 == op2);
        F3_BNE:  taken = (op1 != op2);
        F3_BLT:  taken = $signed(op1) < $signed(op2);
        F3_BGE:  taken = $signed(op1) >= $signed(op2);
        F3_BLTU: taken = op1 < op2;
        F3_BGEU: taken = op1 >= op2;
        default: taken = 1'b0;
    endcase
    taken = taken && (cls == op_branch);
    b = 8'(rdata >> {addr[1:0], 3'b000});
    h = 16'(rdata >> {addr[1], 4'b0000});
    case (f3)
        F3_LB:   ld = xlen_t'($signed(b));
        F3_LBU:  ld = xlen_t'(b);
        F3_LH:   ld = xlen_t'($signed(h));
        F3_LHU:  ld = xlen_t'(h);
        F3_LW:   ld = rdata;
        default: ld = '0;
    endcase
    case (f3)
        F3_SB:   mask = 32'h0000_00ff << {addr[1:0], 3'b000};
        F3_SH:   mask = 32'h0000_ffff << {addr[1], 4'b0000};
        default: mask = 32'hffff_ffff;
    endcase
    // store data repeated across lanes for the mask to pick
    case (f3)
        F3_SB:   sdata = {4{reg2[7:0]}};
        F3_SH:   sdata = {2{reg2[15:0]}};
        default: sdata = reg2;
    endcase
    e.mem_req   = (cls == op_load) || (cls == op_store);
    e.mem_we    = (cls == op_store);
    e.mem_raddr = e.mem_req ? addr : '0;
    e.mem_waddr = e.mem_we ? addr : '0;
    e.mem_wdata = e.mem_we ? ((rdata & ~mask) | (sdata & mask)) : '0;
    e.reg_we    = reg_we && (cls inside {op_alu_imm, op_alu_reg, op_load});
    e.reg_wdata = (cls == op_load) ? ld : alu;
    e.jump_flag = taken;
    e.jump_addr = taken ? op1_jump + op2_jump : '0;
    return e;
endfunction

`endif

//--- bench/tb_ex.sv
`timescale 1ns/10ps

module tb_ex import ex_core_pkg::*; import ex_isa_pkg::*; ();

`include "ex_ref_model.svh"

    localparam int RESET_CYCLES = 10;
    localparam int N_INST       = 200;
    localparam int N_TESTS      = 6;
    // each test adds two idle cycles, the rest is margin
    localparam int MAX_CYCLES   = N_TESTS * (N_INST + 2) + RESET_CYCLES + 278;

    logic      clk;
    logic      rst_n;
    inst_u     inst;
    xlen_t     op1, op2, op1_jump, op2_jump, reg1, reg2;
    logic      reg_we;
    reg_addr_t reg_waddr;
    xlen_t     mem_rdata;
    xlen_t     mem_salt = '0;

    logic      mem_req, mem_we;
    xlen_t     mem_raddr, mem_waddr, mem_wdata;
    logic      reg_we_q;
    reg_addr_t reg_waddr_q;
    xlen_t     reg_wdata_q;
    logic      jump_flag;
    xlen_t     jump_addr;

    ex_exp_t   exp_now;
    ex_exp_t   exp_prev;
    reg_addr_t waddr_prev;
    logic      prev_valid = 1'b0;
    int        n_checks   = 0;
    int        n_errors   = 0;
    int        cycles     = 0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign mem_rdata = ex_mem_word(mem_raddr, mem_salt); // same-cycle memory

    ex_top dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .op1_i        (op1),
        .op2_i        (op2),
        .op1_jump_i   (op1_jump),
        .op2_jump_i   (op2_jump),
        .reg1_rdata_i (reg1),
        .reg2_rdata_i (reg2),
        .reg_we_i     (reg_we),
        .reg_waddr_i  (reg_waddr),
        .mem_rdata_i  (mem_rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_raddr_o  (mem_raddr),
        .mem_waddr_o  (mem_waddr),
        .mem_wdata_o  (mem_wdata),
        .reg_we_o     (reg_we_q),
        .reg_waddr_o  (reg_waddr_q),
        .reg_wdata_o  (reg_wdata_q),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

    task automatic compare_value(input string name, input xlen_t got, input xlen_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic drive_idle();
        inst      = '0;
        op1       = '0;
        op2       = '0;
        op1_jump  = '0;
        op2_jump  = '0;
        reg1      = '0;
        reg2      = '0;
        reg_we    = 1'b0;
        reg_waddr = '0;
    endtask

    // idx walks funct3 and, every 8 instructions, the memory lane
    task automatic drive_inst(input op_class_e cls, input int idx);
        inst_u      w;
        logic [2:0] f3;
        logic [1:0] lane;
        w         = $urandom;
        lane      = 2'(idx / 8);
        op1       = $urandom;
        op2       = (idx % 3 == 0) ? op1 : $urandom; // equal operands for beq/bge
        op1_jump  = $urandom;
        op2_jump  = $urandom;
        reg1      = $urandom;
        reg2      = $urandom;
        reg_we    = 1'($urandom);
        reg_waddr = 5'($urandom);
        case (cls)
            op_alu_imm: begin
                w.r.opcode = OPC_ALU_IMM;
                f3 = 3'(idx);
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    w.r.funct7 = {1'b0, (f3 == F3_SR) && w.r.funct7[5], 5'b0};
                end
            end
            op_alu_reg: begin
                w.r.opcode = OPC_ALU_REG;
                f3 = 3'(idx);
                w.r.funct7 = {1'b0, (f3 == F3_ADD_SUB || f3 == F3_SR) && w.r.funct7[5], 5'b0};
            end
            op_branch: begin
                w.r.opcode = OPC_BRANCH;
                f3 = (idx % 6 < 2) ? 3'(idx % 6) : 3'(idx % 6 + 2);
            end
            op_load: begin
                w.r.opcode = OPC_LOAD;
                f3 = (idx % 5 < 3) ? 3'(idx % 5) : 3'(idx % 5 + 1);
            end
            default: begin
                w.r.opcode = OPC_STORE;
                f3 = 3'(idx % 3);
            end
        endcase
        w.r.funct3 = f3;
        if (cls == op_load || cls == op_store) begin
            op2[1:0] = lane - op1[1:0];
        end
        inst = w;
    endtask

    task automatic report_test(input string name, input int errs);
        $display("%-8s done, %0d errors", name, errs);
    endtask

    task automatic apply_reset();
        int errs_before;
        errs_before = n_errors;
        rst_n = 1'b0;
        // outputs stay quiet under live traffic
        for (int i = 0; i < RESET_CYCLES; i++) begin
            case (i % 3)
                0:       drive_inst(op_store, i);
                1:       drive_inst(op_branch, 0); // beq on equal operands
                default: drive_inst(op_alu_reg, i);
            endcase
            reg_we = 1'b1;
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;
        drive_idle();
        @(posedge clk);
        report_test("reset", n_errors - errs_before);
    endtask

    // op_none picks a random class per instruction
    task automatic run_test(input string name, input op_class_e cls);
        int        errs_before;
        op_class_e kind;
        errs_before = n_errors;
        for (int i = 0; i < N_INST; i++) begin
            kind = cls;
            if (cls == op_none) begin
                kind = op_class_e'(3'($urandom_range(1, 5)));
            end
            @(posedge clk);
            #1;
            if (i == 0) begin
                mem_salt = $urandom;
            end
            drive_inst(kind, i);
        end
        @(posedge clk);
        #1;
        drive_idle();
        @(posedge clk); // last registered result checked by now
        report_test(name, n_errors - errs_before);
    endtask

    // memory outputs against this cycle, registered ones against the last
    always @(negedge clk) begin
        xlen_t rdata;
        rdata   = ex_mem_word(op1 + op2, mem_salt);
        exp_now = ex_ref(inst, op1, op2, op1_jump, op2_jump, reg1, reg2, reg_we, rdata);
        if (!rst_n) begin
            compare_value("mem_req_o", xlen_t'(mem_req), '0);
            compare_value("mem_we_o", xlen_t'(mem_we), '0);
        end else begin
            compare_value("mem_req_o", xlen_t'(mem_req), xlen_t'(exp_now.mem_req));
            compare_value("mem_we_o", xlen_t'(mem_we), xlen_t'(exp_now.mem_we));
            compare_value("mem_raddr_o", mem_raddr, exp_now.mem_raddr);
            compare_value("mem_waddr_o", mem_waddr, exp_now.mem_waddr);
            compare_value("mem_wdata_o", mem_wdata, exp_now.mem_wdata);
        end
        if (!prev_valid) begin
            compare_value("reg_we_o", xlen_t'(reg_we_q), '0);
            compare_value("reg_wdata_o", reg_wdata_q, '0);
            compare_value("jump_flag_o", xlen_t'(jump_flag), '0);
            compare_value("jump_addr_o", jump_addr, '0);
        end else begin
            compare_value("reg_we_o", xlen_t'(reg_we_q), xlen_t'(exp_prev.reg_we));
            compare_value("reg_waddr_o", xlen_t'(reg_waddr_q), xlen_t'(waddr_prev));
            compare_value("reg_wdata_o", reg_wdata_q, exp_prev.reg_wdata);
            compare_value("jump_flag_o", xlen_t'(jump_flag), xlen_t'(exp_prev.jump_flag));
            compare_value("jump_addr_o", jump_addr, exp_prev.jump_addr);
        end
        exp_prev   = exp_now;
        waddr_prev = reg_waddr;
        prev_valid = rst_n;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h7675b306));
        rst_n = 1'b0;
        drive_idle();
        apply_reset();
        run_test("alu_imm", op_alu_imm);
        run_test("alu_reg", op_alu_reg);
        run_test("branch", op_branch);
        run_test("load", op_load);
        run_test("store", op_store);
        run_test("mixed", op_none);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog/ex_top.sv
`timescale 1ns/10ps

module ex_top import ex_core_pkg::*; import ex_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  inst_u     inst_i,
    input  xlen_t     op1_i,
    input  xlen_t     op2_i,
    input  xlen_t     op1_jump_i,
    input  xlen_t     op2_jump_i,
    input  xlen_t     reg1_rdata_i,
    input  xlen_t     reg2_rdata_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_waddr_i,
    input  xlen_t     mem_rdata_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output xlen_t     mem_raddr_o,
    output xlen_t     mem_waddr_o,
    output xlen_t     mem_wdata_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output xlen_t     reg_wdata_o,
    output logic      jump_flag_o,
    output xlen_t     jump_addr_o
);

    xlen_t alu_result;
    logic  branch_taken;
    xlen_t branch_target;
    xlen_t load_data;

    ex_ctrl_if ctrl_if ();

    ex_decode u_decode (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .inst_i   (inst_i),
        .reg_we_i (reg_we_i),
        .ctrl     (ctrl_if.decode)
    );

    ex_alu u_alu (
        .op1_i           (op1_i),
        .op2_i           (op2_i),
        .op1_jump_i      (op1_jump_i),
        .op2_jump_i      (op2_jump_i),
        .reg1_rdata_i    (reg1_rdata_i),
        .reg2_rdata_i    (reg2_rdata_i),
        .ctrl            (ctrl_if.alu),
        .alu_result_o    (alu_result),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    ex_lsu u_lsu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .reg2_rdata_i (reg2_rdata_i),
        .mem_rdata_i  (mem_rdata_i),
        .ctrl         (ctrl_if.lsu),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_raddr_o  (mem_raddr_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .load_data_o  (load_data)
    );

    ex_writeback u_wb (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .reg_waddr_i     (reg_waddr_i),
        .ctrl            (ctrl_if.wb),
        .alu_result_i    (alu_result),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .load_data_i     (load_data),
        .reg_we_o        (reg_we_o),
        .reg_waddr_o     (reg_waddr_o),
        .reg_wdata_o     (reg_wdata_o),
        .jump_flag_o     (jump_flag_o),
        .jump_addr_o     (jump_addr_o)
    );

endmodule

//--- verilog/ex_writeback.sv
`timescale 1ns/10ps

module ex_writeback import ex_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t reg_waddr_i,
    ex_ctrl_if.wb     ctrl,
    input  xlen_t     alu_result_i,
    input  logic      branch_taken_i,
    input  xlen_t     branch_target_i,
    input  xlen_t     load_data_i,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output xlen_t     reg_wdata_o,
    output logic      jump_flag_o,
    output xlen_t     jump_addr_o
);

    xlen_t wdata_next;

    assign wdata_next = (ctrl.op_class == op_load) ? load_data_i : alu_result_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_we_o    <= ctrl.rd_write;
            reg_waddr_o <= reg_waddr_i;
            reg_wdata_o <= wdata_next;
            jump_flag_o <= branch_taken_i;
            jump_addr_o <= branch_taken_i ? branch_target_i : '0; // 0 when not taken
        end
    end

    // branches never write rd, a joint pulse means decode and alu disagree
    a_jump_xor_write: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(jump_flag_o && reg_we_o)
    );

endmodule

//--- verilog/ex_lsu.sv
`timescale 1ns/10ps

module ex_lsu import ex_core_pkg::*; import ex_isa_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    input  xlen_t  reg2_rdata_i,
    input  xlen_t  mem_rdata_i,
    ex_ctrl_if.lsu ctrl,
    output logic   mem_req_o,
    output logic   mem_we_o,
    output xlen_t  mem_raddr_o,
    output xlen_t  mem_waddr_o,
    output xlen_t  mem_wdata_o,
    output xlen_t  load_data_o
);

    xlen_t      addr;
    logic [1:0] lane;
    logic [4:0] byte_pos;
    logic       is_load;
    logic       is_store;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    xlen_t      merged;

    assign addr     = op1_i + op2_i;
    assign lane     = addr[1:0];
    assign byte_pos = {lane, 3'b000};
    assign is_load  = (ctrl.op_class == op_load);
    assign is_store = (ctrl.op_class == op_store);

    assign mem_req_o = rst_n_i && (is_load || is_store);
    assign mem_we_o  = rst_n_i && is_store;

    // stores read too, the merge needs the old word
    assign mem_raddr_o = (is_load || is_store) ? addr : '0;
    assign mem_waddr_o = is_store ? addr : '0;

    assign rd_byte = mem_rdata_i[byte_pos +: 8];
    assign rd_half = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    always_comb begin
        case (ctrl.funct3)
            F3_LB:   load_data_o = {{24{rd_byte[7]}}, rd_byte};
            F3_LBU:  load_data_o = {24'b0, rd_byte};
            F3_LH:   load_data_o = {{16{rd_half[15]}}, rd_half};
            F3_LHU:  load_data_o = {16'b0, rd_half};
            F3_LW:   load_data_o = mem_rdata_i;
            default: load_data_o = '0;
        endcase
    end

    always_comb begin
        merged = mem_rdata_i;
        case (ctrl.funct3)
            F3_SB: merged[byte_pos +: 8] = reg2_rdata_i[7:0];
            F3_SH: begin
                if (lane[1]) begin
                    merged[31:16] = reg2_rdata_i[15:0];
                end else begin
                    merged[15:0] = reg2_rdata_i[15:0];
                end
            end
            F3_SW:   merged = reg2_rdata_i;
            default: merged = mem_rdata_i;
        endcase
    end

    assign mem_wdata_o = is_store ? merged : '0;

    a_we_has_req: assert property (
        @(posedge clk) disable iff (!rst_n_i) mem_we_o |-> mem_req_o
    );

endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/10ps

module ex_alu import ex_core_pkg::*; import ex_isa_pkg::*; (
    input  xlen_t  op1_i,
    input  xlen_t  op2_i,
    input  xlen_t  op1_jump_i,
    input  xlen_t  op2_jump_i,
    input  xlen_t  reg1_rdata_i,
    input  xlen_t  reg2_rdata_i,
    ex_ctrl_if.alu ctrl,
    output xlen_t  alu_result_o,
    output logic   branch_taken_o,
    output xlen_t  branch_target_o
);

    xlen_t sum;
    xlen_t diff;
    logic  lt_s;
    logic  lt_u;
    logic  eq;
    logic  shift_left;
    xlen_t imm_shift;
    xlen_t reg_shift;

    function automatic xlen_t shift_word(input xlen_t val, input logic [4:0] amt,
                                         input logic left, input logic arith);
        if (left) begin
            return val << amt;
        end
        if (arith) begin
            return xlen_t'($signed(val) >>> amt);
        end
        return val >> amt;
    endfunction

    // shared by alu ops and branch compares
    assign sum  = op1_i + op2_i;
    assign diff = op1_i - op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;
    assign eq   = (diff == '0);

    assign shift_left = (ctrl.funct3 == F3_SLL);
    assign imm_shift  = shift_word(reg1_rdata_i, ctrl.shamt, shift_left, ctrl.alt);
    assign reg_shift  = shift_word(reg1_rdata_i, reg2_rdata_i[4:0], shift_left, ctrl.alt);

    always_comb begin
        case (ctrl.funct3)
            F3_ADD_SUB:    alu_result_o = ctrl.alt ? diff : sum;
            F3_SLL, F3_SR: alu_result_o = (ctrl.op_class == op_alu_reg) ? reg_shift : imm_shift;
            F3_SLT:        alu_result_o = {{(XLEN-1){1'b0}}, lt_s};
            F3_SLTU:       alu_result_o = {{(XLEN-1){1'b0}}, lt_u};
            F3_XOR:        alu_result_o = op1_i ^ op2_i;
            F3_OR:         alu_result_o = op1_i | op2_i;
            default:       alu_result_o = op1_i & op2_i;
        endcase
    end

    always_comb begin
        branch_taken_o = 1'b0;
        if (ctrl.op_class == op_branch) begin
            case (ctrl.funct3)
                F3_BEQ:  branch_taken_o = eq;
                F3_BNE:  branch_taken_o = !eq;
                F3_BLT:  branch_taken_o = lt_s;
                F3_BGE:  branch_taken_o = !lt_s;
                F3_BLTU: branch_taken_o = lt_u;
                F3_BGEU: branch_taken_o = !lt_u;
                default: branch_taken_o = 1'b0;
            endcase
        end
    end

    assign branch_target_o = op1_jump_i + op2_jump_i;

endmodule

//--- verilog/ex_decode.sv
`timescale 1ns/10ps

module ex_decode import ex_core_pkg::*; import ex_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  inst_u     inst_i,
    input  logic      reg_we_i,
    ex_ctrl_if.decode ctrl
);

    op_class_e  cls;
    logic [2:0] f3;
    logic       is_sr_imm;

    assign f3 = inst_i.r.funct3;

    always_comb begin
        cls = op_none;
        case (inst_i.r.opcode)
            OPC_ALU_IMM: cls = op_alu_imm;
            OPC_ALU_REG: cls = op_alu_reg;
            OPC_BRANCH: begin
                if (f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    cls = op_branch;
                end
            end
            OPC_LOAD: begin
                if (f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    cls = op_load;
                end
            end
            OPC_STORE: begin
                if (f3 inside {F3_SB, F3_SH, F3_SW}) begin
                    cls = op_store;
                end
            end
            default: cls = op_none;
        endcase
    end

    assign is_sr_imm = (cls == op_alu_imm) && (f3 == F3_SR);

    assign ctrl.op_class = cls;
    assign ctrl.funct3   = f3;
    // sub/sra for register forms, srai for immediates; addi keeps bit 30 as imm
    assign ctrl.alt      = inst_i.r.funct7[5] && ((cls == op_alu_reg) || is_sr_imm);
    assign ctrl.shamt    = (cls == op_alu_imm) ? inst_i.i.imm[4:0] : 5'd0;
    assign ctrl.rd_write = reg_we_i &&
                           (cls inside {op_alu_imm, op_alu_reg, op_load});

    // all downstream units trust op_class, x here would leak everywhere
    a_class_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) !$isunknown(ctrl.op_class)
    );

endmodule

//--- verilog/ex_ctrl_if.sv
`timescale 1ns/10ps

interface ex_ctrl_if import ex_core_pkg::*; ();

    op_class_e  op_class;
    logic [2:0] funct3;
    logic       alt;      // inst bit 30, only where it matters
    logic [4:0] shamt;
    logic       rd_write;

    modport decode (
        output op_class, funct3, alt, shamt, rd_write
    );

    modport alu (
        input op_class, funct3, alt, shamt
    );

    modport lsu (
        input op_class, funct3
    );

    modport wb (
        input op_class, rd_write
    );

endinterface

//--- verilog/ex_isa_pkg.sv
package ex_isa_pkg;

    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl/sra, split by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // imm[4:0] doubles as shamt for the immediate shifts
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

//--- verilog/ex_core_pkg.sv
package ex_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // what decode made of the word, op_none covers anything illegal
    typedef enum logic [2:0] {
        op_none    = 3'd0,
        op_alu_imm = 3'd1,
        op_alu_reg = 3'd2,
        op_branch  = 3'd3,
        op_load    = 3'd4,
        op_store   = 3'd5
    } op_class_e;

endpackage
